// File: adc_capture.f
+incdir+verilog
verilog/adc_data_pkg.sv
verilog/snap_ctrl_pkg.sv
verilog/lane_reorder.sv
verilog/sample_convert.sv
verilog/peak_detect.sv
verilog/snap_buffer.sv
verilog/adc_capture_top.sv
verif/adc_capture_chk.sv
verif/adc_capture_tb.sv

// File: verif/adc_capture_chk.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module adc_capture_chk
(
	input logic                      main_clk,
	input logic                      arst_n_i,
	input adc_data_pkg::adc_raw_t    adc_raw_i,
	input logic                      peak_rst_i,
	input logic                      snap_start_i,
	input logic                      snap_rst_i,
	input snap_ctrl_pkg::snap_addr_t snap_addr_i,
	input adc_data_pkg::adc_word_t   adc_data_o,
	input adc_data_pkg::adc_peak_t   adc_peak_o,
	input logic                      snap_ready_o,
	input adc_data_pkg::sample_t     snap_data_o
);

	int unsigned                    err_cnt = 0;  // Read by the testbench
	logic [1:0]                     live_cnt;     // Clocks since reset, saturating
	snap_ctrl_pkg::snap_state_t     exp_state;
	logic [$clog2(`SNAP_DEPTH)-1:0] cap_cnt;
	adc_data_pkg::adc_word_t        rec [`SNAP_DEPTH];  // Words seen during capture

	task automatic note_fail(input string what);
		err_cnt++;
		$error("%s", what);
	endtask

	// Offset binary and two's complement differ only in the MSB
	function automatic adc_data_pkg::sample_t flip_msb(input adc_data_pkg::sample_t s);
		return {~s[`ADC_SAMPLE_W-1], s[`ADC_SAMPLE_W-2:0]};
	endfunction

	function automatic adc_data_pkg::adc_word_t expect_word(input adc_data_pkg::adc_raw_t r);
		adc_data_pkg::adc_word_t w;
		for (int c = 0; c < `ADC_CORE_NUM; c++)
			for (int m = 0; m < `ADC_LANE_SAMPLES; m++)
			begin
				w[c][2*m]   = flip_msb(r[c].lane_l[m]);  // Low lane on even slots
				w[c][2*m+1] = flip_msb(r[c].lane_h[m]);
			end
		return w;
	endfunction

	// Exact pair after a restart, otherwise the pair encloses the word
	function automatic logic peaks_check(input adc_data_pkg::adc_peak_t p,
			input adc_data_pkg::adc_word_t w, input logic exact);
		adc_data_pkg::sample_t hi;
		adc_data_pkg::sample_t lo;
		logic ok;
		ok = 1'b1;
		for (int c = 0; c < `ADC_CORE_NUM; c++)
		begin
			hi = flip_msb(w[c][0]);
			lo = hi;
			for (int s = 1; s < `ADC_CORE_SAMPLES; s++)
			begin
				if (flip_msb(w[c][s]) > hi)
					hi = flip_msb(w[c][s]);
				if (flip_msb(w[c][s]) < lo)
					lo = flip_msb(w[c][s]);
			end
			if (exact)
				ok &= (p[c].max == hi) && (p[c].min == lo);
			else
				ok &= (p[c].max >= hi) && (p[c].min <= lo);
		end
		return ok;
	endfunction

	function automatic logic peaks_grow(input adc_data_pkg::adc_peak_t cur,
			input adc_data_pkg::adc_peak_t prev);
		logic ok;
		ok = 1'b1;
		for (int c = 0; c < `ADC_CORE_NUM; c++)
			ok &= (cur[c].max >= prev[c].max) && (cur[c].min <= prev[c].min);
		return ok;
	endfunction

	// Address is word x 16 + core x 4 + sample
	function automatic adc_data_pkg::sample_t recorded(input snap_ctrl_pkg::snap_addr_t a);
		int w_idx;
		int c_idx;
		int s_idx;
		w_idx = a / (`ADC_CORE_NUM * `ADC_CORE_SAMPLES);
		c_idx = (a / `ADC_CORE_SAMPLES) % `ADC_CORE_NUM;
		s_idx = a % `ADC_CORE_SAMPLES;
		return rec[w_idx][c_idx][s_idx];
	endfunction

	////////////////////////////////////////////////////
	// Expected snapshot state
	////////////////////////////////////////////////////
	always_ff @(posedge main_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			live_cnt <= '0;
		else if (live_cnt != 2'd3)
			live_cnt <= live_cnt + 1'b1;
	end

	always_ff @(posedge main_clk or negedge arst_n_i)
	begin
		if (!arst_n_i || snap_rst_i)
		begin
			exp_state <= snap_ctrl_pkg::SNAP_IDLE;
			cap_cnt   <= '0;
		end
		else if (exp_state == snap_ctrl_pkg::SNAP_CAPTURE)
		begin
			cap_cnt <= cap_cnt + 1'b1;
			if (cap_cnt == `SNAP_DEPTH - 1)
				exp_state <= snap_ctrl_pkg::SNAP_DONE;
		end
		else if (snap_start_i)
		begin
			exp_state <= snap_ctrl_pkg::SNAP_CAPTURE;
			cap_cnt   <= '0;
		end
	end

	always_ff @(posedge main_clk)
	begin
		if (exp_state == snap_ctrl_pkg::SNAP_CAPTURE && !snap_rst_i)
			rec[cap_cnt] <= adc_data_o;
	end

	////////////////////////////////////////////////////
	// Assertions
	////////////////////////////////////////////////////
	a_data_order: assert property (@(posedge main_clk) disable iff (!arst_n_i)
		live_cnt >= 2 |-> adc_data_o == expect_word($past(adc_raw_i, 2)))
		else note_fail("adc_data_o is not the interleaved, sign converted raw input");

	a_peak_bounds: assert property (@(posedge main_clk) disable iff (!arst_n_i)
		live_cnt >= 2 |-> peaks_check(adc_peak_o, adc_data_o, 1'b0))
		else note_fail("adc_peak_o does not enclose the current word");

	a_peak_grow: assert property (@(posedge main_clk) disable iff (!arst_n_i)
		live_cnt >= 2 && !$past(peak_rst_i) |-> peaks_grow(adc_peak_o, $past(adc_peak_o)))
		else note_fail("adc_peak_o shrank without a restart");

	a_peak_restart: assert property (@(posedge main_clk) disable iff (!arst_n_i)
		live_cnt >= 2 && $past(peak_rst_i) |-> peaks_check(adc_peak_o, adc_data_o, 1'b1))
		else note_fail("adc_peak_o after a restart is not the pair of one word");

	a_ready_seq: assert property (@(posedge main_clk) disable iff (!arst_n_i || snap_rst_i)
		snap_start_i && exp_state != snap_ctrl_pkg::SNAP_CAPTURE
		|=> !snap_ready_o [*`SNAP_DEPTH] ##1 snap_ready_o)
		else note_fail("snap_ready_o did not rise exactly after a full capture");

	a_ready_state: assert property (@(posedge main_clk) disable iff (!arst_n_i)
		snap_ready_o == (exp_state == snap_ctrl_pkg::SNAP_DONE))
		else note_fail("snap_ready_o differs from the capture state");

	a_snap_read: assert property (@(posedge main_clk) disable iff (!arst_n_i)
		exp_state == snap_ctrl_pkg::SNAP_DONE && $past(exp_state) == snap_ctrl_pkg::SNAP_DONE
		|-> snap_data_o == recorded($past(snap_addr_i)))
		else note_fail("snap_data_o does not match the captured sample");

endmodule

// File: verif/adc_capture_tb.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module adc_capture_tb;

	localparam int ADDR_NUM    = `SNAP_DEPTH * `ADC_CORE_NUM * `ADC_CORE_SAMPLES;
	localparam int RAMP_LEN    = 40;
	localparam int RAND_LEN    = 64;
	localparam int RESTART_LEN = 30;
	localparam int CAPTURE_LEN = `SNAP_DEPTH + ADDR_NUM + 8;  // Fill and a full address sweep
	localparam int ABORT_LEN   = 3 * `SNAP_DEPTH + 20;
	localparam int TIMEOUT_CYCLES =
		2 * (3 + RAMP_LEN + RAND_LEN + 4 + RESTART_LEN + CAPTURE_LEN + ABORT_LEN);

	logic                      main_clk;
	logic                      arst_n_i;
	adc_data_pkg::adc_raw_t    adc_raw_i;
	logic                      peak_rst_i;
	logic                      snap_start_i;
	logic                      snap_rst_i;
	snap_ctrl_pkg::snap_addr_t snap_addr_i;
	adc_data_pkg::adc_word_t   adc_data_o;
	adc_data_pkg::adc_peak_t   adc_peak_o;
	logic                      snap_ready_o;
	adc_data_pkg::sample_t     snap_data_o;

	int seed;
	int ramp_base;   // First sample value of the next ramp word
	int tb_err;
	int err_mark;
	int test_pass;
	int test_fail;
	int cycle_cnt;
	adc_data_pkg::adc_peak_t exp_peak;  // Running model of the random test

	adc_capture_top uut
	(
		.main_clk     (main_clk),
		.arst_n_i     (arst_n_i),
		.adc_raw_i    (adc_raw_i),
		.peak_rst_i   (peak_rst_i),
		.snap_start_i (snap_start_i),
		.snap_rst_i   (snap_rst_i),
		.snap_addr_i  (snap_addr_i),
		.adc_data_o   (adc_data_o),
		.adc_peak_o   (adc_peak_o),
		.snap_ready_o (snap_ready_o),
		.snap_data_o  (snap_data_o)
	);

	bind adc_capture_top adc_capture_chk u_chk
	(
		.main_clk     (main_clk),
		.arst_n_i     (arst_n_i),
		.adc_raw_i    (adc_raw_i),
		.peak_rst_i   (peak_rst_i),
		.snap_start_i (snap_start_i),
		.snap_rst_i   (snap_rst_i),
		.snap_addr_i  (snap_addr_i),
		.adc_data_o   (adc_data_o),
		.adc_peak_o   (adc_peak_o),
		.snap_ready_o (snap_ready_o),
		.snap_data_o  (snap_data_o)
	);

	initial
	begin
		main_clk = 1'b0;
		forever #5 main_clk = ~main_clk;
	end

	////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////
	// Consecutive values in word order after the interleave
	function automatic adc_data_pkg::adc_raw_t ramp_word(input int base);
		adc_data_pkg::adc_raw_t w;
		for (int c = 0; c < `ADC_CORE_NUM; c++)
			for (int m = 0; m < `ADC_LANE_SAMPLES; m++)
			begin
				w[c].lane_l[m] = adc_data_pkg::sample_t'(base + c * `ADC_CORE_SAMPLES + 2 * m);
				w[c].lane_h[m] = adc_data_pkg::sample_t'(base + c * `ADC_CORE_SAMPLES + 2 * m + 1);
			end
		return w;
	endfunction

	task automatic random_word(output adc_data_pkg::adc_raw_t w);
		for (int c = 0; c < `ADC_CORE_NUM; c++)
			for (int m = 0; m < `ADC_LANE_SAMPLES; m++)
			begin
				w[c].lane_l[m] = adc_data_pkg::sample_t'($random(seed));
				w[c].lane_h[m] = adc_data_pkg::sample_t'($random(seed));
			end
	endtask

	// Unsigned max and min of every sample since the load
	task automatic peak_model(input adc_data_pkg::adc_raw_t w, input logic load);
		adc_data_pkg::sample_t s;
		for (int c = 0; c < `ADC_CORE_NUM; c++)
		begin
			if (load)
			begin
				exp_peak[c].max = '0;
				exp_peak[c].min = '1;
			end
			for (int i = 0; i < 2 * `ADC_LANE_SAMPLES; i++)
			begin
				s = i[0] ? w[c].lane_h[i/2] : w[c].lane_l[i/2];
				if (s > exp_peak[c].max)
					exp_peak[c].max = s;
				if (s < exp_peak[c].min)
					exp_peak[c].min = s;
			end
		end
	endtask

	task automatic tick();
		@(negedge main_clk);
		adc_raw_i = ramp_word(ramp_base);
		ramp_base += `ADC_CORE_NUM * `ADC_CORE_SAMPLES;
	endtask

	task automatic start_capture();
		tick();
		snap_start_i = 1'b1;
		tick();
		snap_start_i = 1'b0;
	endtask

	task automatic wait_ready(input string name);
		int n;
		n = 0;
		while (!snap_ready_o && n < 4 * `SNAP_DEPTH)
		begin
			tick();
			n++;
		end
		if (!snap_ready_o)
		begin
			$display("%s: snap_ready_o never rose after the capture started", name);
			tb_err++;
		end
	endtask

	////////////////////////////////////////////////////
	// Bookkeeping
	////////////////////////////////////////////////////
	function automatic int error_total();
		return tb_err + int'(uut.u_chk.err_cnt);  // Own checks plus assertion failures
	endfunction

	task automatic finish_test(input string name);
		int n;
		n = error_total() - err_mark;
		if (n == 0)
		begin
			test_pass++;
			$display("%-8s passed", name);
		end
		else
		begin
			test_fail++;
			$display("%-8s FAILED with %0d errors", name, n);
		end
		err_mark = error_total();
	endtask

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge main_clk);
			cycle_cnt++;
		end
		$display("Timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		adc_data_pkg::adc_raw_t w;
		seed         = 32'hf575;
		tb_err       = 0;
		err_mark     = 0;
		test_pass    = 0;
		test_fail    = 0;
		ramp_base    = 0;
		arst_n_i     = 1'b0;
		adc_raw_i    = '0;
		peak_rst_i   = 1'b0;
		snap_start_i = 1'b0;
		snap_rst_i   = 1'b0;
		snap_addr_i  = '0;
		repeat (3) @(negedge main_clk);
		arst_n_i = 1'b1;

		repeat (RAMP_LEN) tick();
		finish_test("ramp");

		// Restart lands on the first random word
		for (int i = 0; i < RAND_LEN; i++)
		begin
			@(negedge main_clk);
			random_word(w);
			adc_raw_i  = w;
			peak_rst_i = (i == 1);
			peak_model(w, i == 0);
		end
		repeat (3) @(negedge main_clk);  // Pipeline drains with the last word held
		for (int c = 0; c < `ADC_CORE_NUM; c++)
		begin
			if (adc_peak_o[c].max !== exp_peak[c].max)
			begin
				$display("Fail random core %0d max: expected %h, actual %h",
					c, exp_peak[c].max, adc_peak_o[c].max);
				tb_err++;
			end
			if (adc_peak_o[c].min !== exp_peak[c].min)
			begin
				$display("Fail random core %0d min: expected %h, actual %h",
					c, exp_peak[c].min, adc_peak_o[c].min);
				tb_err++;
			end
		end
		finish_test("random");

		for (int i = 0; i < RESTART_LEN; i++)
		begin
			@(negedge main_clk);
			random_word(w);
			adc_raw_i  = w;
			peak_rst_i = (i % 7 == 3);
		end
		@(negedge main_clk);
		peak_rst_i = 1'b0;
		finish_test("restart");

		repeat (2) tick();  // Ramp words reach adc_data_o before the capture
		start_capture();
		wait_ready("capture");
		for (int a = 0; a < ADDR_NUM; a++)
		begin
			tick();
			snap_addr_i = snap_ctrl_pkg::snap_addr_t'(a);
		end
		repeat (3) tick();
		finish_test("capture");

		start_capture();
		repeat (6) tick();
		snap_rst_i = 1'b1;  // Abort mid capture
		repeat (2) tick();
		snap_rst_i = 1'b0;
		repeat (2 * `SNAP_DEPTH) tick();
		if (snap_ready_o)
		begin
			$display("abort: snap_ready_o rose without a new capture");
			tb_err++;
		end
		start_capture();
		wait_ready("abort");
		repeat (2) tick();
		finish_test("abort");

		$display("Tests passed %0d, failed %0d, errors %0d", test_pass, test_fail, error_total());
		if (test_fail == 0 && error_total() == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: verilog/adc_capture_top.sv
`timescale 1ns/1ps

module adc_capture_top
(
	input  logic                      main_clk,
	input  logic                      arst_n_i,

	// Lanes from cores A to D
	input  adc_data_pkg::adc_raw_t    adc_raw_i,

	// Peak tracking
	input  logic                      peak_rst_i,    // Restart pulse

	// Snapshot control and readback
	input  logic                      snap_start_i,
	input  logic                      snap_rst_i,
	input  snap_ctrl_pkg::snap_addr_t snap_addr_i,

	output adc_data_pkg::adc_word_t   adc_data_o,    // Two's complement, ordered
	output adc_data_pkg::adc_peak_t   adc_peak_o,    // Unsigned max and min per core
	output logic                      snap_ready_o,
	output adc_data_pkg::sample_t     snap_data_o
);

	// Interleaved but still offset binary
	adc_data_pkg::adc_word_t ordered_word;

	////////////////////////////////////////////////////
	// Lane interleave
	////////////////////////////////////////////////////
	lane_reorder u_lane_reorder
	(
		.main_clk  (main_clk),
		.arst_n_i  (arst_n_i),
		.raw_i     (adc_raw_i),
		.ordered_o (ordered_word)
	);

	////////////////////////////////////////////////////
	// Parallel branches on the ordered word
	////////////////////////////////////////////////////
	sample_convert u_sample_convert
	(
		.main_clk  (main_clk),
		.arst_n_i  (arst_n_i),
		.ordered_i (ordered_word),
		.signed_o  (adc_data_o)
	);

	// Same latency as the converted data
	peak_detect u_peak_detect
	(
		.main_clk  (main_clk),
		.arst_n_i  (arst_n_i),
		.ordered_i (ordered_word),
		.restart_i (peak_rst_i),
		.peak_o    (adc_peak_o)
	);

	////////////////////////////////////////////////////
	// Snapshot of converted words
	////////////////////////////////////////////////////
	snap_buffer u_snap_buffer
	(
		.main_clk (main_clk),
		.arst_n_i (arst_n_i),
		.word_i   (adc_data_o),
		.start_i  (snap_start_i),
		.clear_i  (snap_rst_i),
		.addr_i   (snap_addr_i),
		.ready_o  (snap_ready_o),
		.data_o   (snap_data_o)
	);

endmodule

// File: verilog/adc_consts.svh
`ifndef ADC_CONSTS_SVH
`define ADC_CONSTS_SVH

////////////////////////////////////////////////////
// Sample and lane geometry
////////////////////////////////////////////////////
`define ADC_SAMPLE_W      8   // Bits per sample
`define ADC_LANE_SAMPLES  2   // Samples per lane per clock
`define ADC_CORE_SAMPLES  4   // Both lanes of one core
`define ADC_CORE_NUM      4   // Cores A to D

////////////////////////////////////////////////////
// Snapshot buffer
////////////////////////////////////////////////////
`define SNAP_DEPTH        16  // Words per capture

// Covers depth x cores x samples per core
`define SNAP_ADDR_W       8

`endif

// File: verilog/adc_data_pkg.sv
`include "adc_consts.svh"

package adc_data_pkg;

	////////////////////////////////////////////////////
	// Raw lanes as delivered by the cores
	////////////////////////////////////////////////////
	typedef logic [`ADC_SAMPLE_W-1:0] sample_t;

	typedef sample_t [`ADC_LANE_SAMPLES-1:0] lane_t;

	typedef struct packed
	{
		lane_t lane_h;  // Odd positions of the core word
		lane_t lane_l;  // Even positions
	} core_raw_t;

	typedef core_raw_t [`ADC_CORE_NUM-1:0] adc_raw_t;

	////////////////////////////////////////////////////
	// Ordered words, index 0 is the earliest sample
	////////////////////////////////////////////////////
	typedef sample_t [`ADC_CORE_SAMPLES-1:0] core_word_t;

	typedef core_word_t [`ADC_CORE_NUM-1:0] adc_word_t;

	// Running extremes of one core, unsigned compare
	typedef struct packed
	{
		sample_t max;
		sample_t min;
	} peak_t;

	typedef peak_t [`ADC_CORE_NUM-1:0] adc_peak_t;

endpackage

// File: verilog/lane_reorder.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module lane_reorder
(
	input  logic                   main_clk,
	input  logic                   arst_n_i,
	input  adc_data_pkg::adc_raw_t raw_i,
	output adc_data_pkg::adc_word_t ordered_o
);

	wire adc_data_pkg::adc_word_t ordered_d;  // Interleaved, before the register

	////////////////////////////////////////////////////
	// Low lane on even slots, high lane on odd slots
	////////////////////////////////////////////////////
	genvar c;
	genvar m;
	generate
		for (c = 0; c < `ADC_CORE_NUM; c++)
		begin : g_core
			for (m = 0; m < `ADC_LANE_SAMPLES; m++)
			begin : g_smp
				assign ordered_d[c][2*m]   = raw_i[c].lane_l[m];
				assign ordered_d[c][2*m+1] = raw_i[c].lane_h[m];
			end
		end
	endgenerate

	always_ff @(posedge main_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			ordered_o <= '0;
		else
			ordered_o <= ordered_d;  // One cycle latency
	end

endmodule

// File: verilog/peak_detect.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module peak_detect
(
	input  logic                    main_clk,
	input  logic                    arst_n_i,
	input  adc_data_pkg::adc_word_t ordered_i,
	input  logic                    restart_i,  // Reload from the current word
	output adc_data_pkg::adc_peak_t peak_o
);

	adc_data_pkg::adc_peak_t word_peak;  // Extremes of this clock's word only

	// Max and min over the samples of one core word
	function automatic adc_data_pkg::peak_t core_peak(input adc_data_pkg::core_word_t w);
		adc_data_pkg::peak_t p;
		p.max = w[0];
		p.min = w[0];
		for (int s = 1; s < `ADC_CORE_SAMPLES; s++)
		begin
			if (w[s] > p.max)
				p.max = w[s];
			if (w[s] < p.min)
				p.min = w[s];
		end
		return p;
	endfunction

	always_comb
	begin
		for (int c = 0; c < `ADC_CORE_NUM; c++)
			word_peak[c] = core_peak(ordered_i[c]);
	end

	////////////////////////////////////////////////////
	// Running pair per core
	////////////////////////////////////////////////////
	always_ff @(posedge main_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			for (int c = 0; c < `ADC_CORE_NUM; c++)
			begin
				peak_o[c].max <= '0;
				peak_o[c].min <= '1;  // So the first sample always wins
			end
		end
		else if (restart_i)
			peak_o <= word_peak;
		else
		begin
			for (int c = 0; c < `ADC_CORE_NUM; c++)
			begin
				if (word_peak[c].max > peak_o[c].max)
					peak_o[c].max <= word_peak[c].max;
				if (word_peak[c].min < peak_o[c].min)
					peak_o[c].min <= word_peak[c].min;
			end
		end
	end

endmodule

// File: verilog/sample_convert.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module sample_convert
(
	input  logic                    main_clk,
	input  logic                    arst_n_i,
	input  adc_data_pkg::adc_word_t ordered_i,
	output adc_data_pkg::adc_word_t signed_o
);

	// Offset binary becomes two's complement by flipping the MSB
	localparam adc_data_pkg::sample_t SIGN_MASK = adc_data_pkg::sample_t'(1) << (`ADC_SAMPLE_W-1);

	adc_data_pkg::adc_word_t signed_d;

	always_comb
	begin
		for (int c = 0; c < `ADC_CORE_NUM; c++)
			for (int s = 0; s < `ADC_CORE_SAMPLES; s++)
				signed_d[c][s] = ordered_i[c][s] ^ SIGN_MASK;
	end

	always_ff @(posedge main_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			signed_o <= '0;
		else
			signed_o <= signed_d;
	end

endmodule

// File: verilog/snap_buffer.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module snap_buffer
(
	input  logic                     main_clk,
	input  logic                     arst_n_i,
	input  adc_data_pkg::adc_word_t  word_i,   // Converted data
	input  logic                     start_i,  // Capture request pulse
	input  logic                     clear_i,  // Abort, held as a level
	input  snap_ctrl_pkg::snap_addr_t addr_i,
	output logic                     ready_o,
	output adc_data_pkg::sample_t    data_o
);

	localparam int WR_CNT_W   = $clog2(`SNAP_DEPTH);
	localparam int CORE_SEL_W = $clog2(`ADC_CORE_NUM);
	localparam int SMP_SEL_W  = $clog2(`ADC_CORE_SAMPLES);

	snap_ctrl_pkg::snap_state_t state;
	logic [WR_CNT_W-1:0]        wr_cnt;
	logic                       wr_en;
	logic                       last_wr;

	adc_data_pkg::adc_word_t    mem [`SNAP_DEPTH];

	logic [WR_CNT_W-1:0]        rd_word;
	logic [CORE_SEL_W-1:0]      rd_core;
	logic [SMP_SEL_W-1:0]       rd_smp;

	assign wr_en   = (state == snap_ctrl_pkg::SNAP_CAPTURE) && !clear_i;
	assign last_wr = (wr_cnt == WR_CNT_W'(`SNAP_DEPTH-1));

	////////////////////////////////////////////////////
	// Capture FSM
	////////////////////////////////////////////////////
	always_ff @(posedge main_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state   <= snap_ctrl_pkg::SNAP_IDLE;
			wr_cnt  <= '0;
			ready_o <= 1'b0;
		end
		else if (clear_i)
		begin
			// Abort wins over a pending start
			state   <= snap_ctrl_pkg::SNAP_IDLE;
			wr_cnt  <= '0;
			ready_o <= 1'b0;
		end
		else
		begin
			case (state)
				snap_ctrl_pkg::SNAP_IDLE,
				snap_ctrl_pkg::SNAP_DONE:
				begin
					if (start_i)
					begin
						state   <= snap_ctrl_pkg::SNAP_CAPTURE;
						wr_cnt  <= '0;
						ready_o <= 1'b0;
					end
				end
				snap_ctrl_pkg::SNAP_CAPTURE:
				begin
					wr_cnt <= wr_cnt + 1'b1;
					if (last_wr)
					begin
						state   <= snap_ctrl_pkg::SNAP_DONE;
						ready_o <= 1'b1;  // Rises with the last write
					end
				end
				default:
					state <= snap_ctrl_pkg::SNAP_IDLE;
			endcase
		end
	end

	// Sample storage, one word per entry
	always_ff @(posedge main_clk)
	begin
		if (wr_en)
			mem[wr_cnt] <= word_i;
	end

	////////////////////////////////////////////////////
	// Read port, word x 16 + core x 4 + sample
	////////////////////////////////////////////////////
	assign rd_smp  = addr_i[SMP_SEL_W-1:0];
	assign rd_core = addr_i[SMP_SEL_W +: CORE_SEL_W];
	assign rd_word = addr_i[SMP_SEL_W+CORE_SEL_W +: WR_CNT_W];

	always_ff @(posedge main_clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			data_o <= '0;
		else
			data_o <= mem[rd_word][rd_core][rd_smp];  // One cycle after the address
	end

endmodule

// File: verilog/snap_ctrl_pkg.sv
`include "adc_consts.svh"

package snap_ctrl_pkg;

	////////////////////////////////////////////////////
	// Snapshot control
	////////////////////////////////////////////////////

	// Capture FSM
	typedef enum logic [1:0]
	{
		SNAP_IDLE    = 2'd0,
		SNAP_CAPTURE = 2'd1,  // Writing one word per clock
		SNAP_DONE    = 2'd2   // Buffer full, readable
	} snap_state_t;

	// Word index, core and sample packed from MSB down
	typedef logic [`SNAP_ADDR_W-1:0] snap_addr_t;

endpackage
